/* design/merger_cfg_pkg.sv */
package merger_cfg_pkg;

    // Defaults for the top level, the testbench reads them too
    parameter int NUM_SOURCES_DEF = 4;
    parameter int QUEUE_DEPTH_DEF = 8;  // Must be a power of two

    // Width of one packet word
    parameter int DATA_WIDTH = 16;

endpackage

/* design/merger_types_pkg.sv */
package merger_types_pkg;

    import merger_cfg_pkg::*;

    // One word of a packet
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Packet lock of the drain side
    typedef enum logic {
        IDLE,    // Free to pick any source
        LOCKED   // Draining one source until its last word
    } drain_state_t;

endpackage

/* design/source_queue.sv */
`timescale 1ns/1ps

module source_queue #(
    parameter int QUEUE_DEPTH = merger_cfg_pkg::QUEUE_DEPTH_DEF,
    localparam int PTR_W = $clog2(QUEUE_DEPTH)
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    push,
    input  merger_types_pkg::data_t push_data,
    input  logic                    push_last,
    input  logic                    pop,
    output merger_types_pkg::data_t head_data,
    output logic                    head_last,
    output logic                    not_empty,
    output logic                    full
);

    import merger_types_pkg::*;

    data_t            data_mem [QUEUE_DEPTH];
    logic             last_mem [QUEUE_DEPTH];   // Last-of-packet flag per word
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // Push into a full queue is dropped
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= push_data;
            last_mem[wr_ptr] <= push_last;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

    assign head_data = data_mem[rd_ptr];
    assign head_last = last_mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (PTR_W + 1)'(QUEUE_DEPTH));

endmodule

/* design/fair_arbiter.sv */
`timescale 1ns/1ps

module fair_arbiter #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [NUM_SOURCES-1:0] request,
    input  logic [NUM_SOURCES-1:0] hold,        // Keep the priority where it is
    output logic [SRC_W-1:0]       grant,
    output logic [NUM_SOURCES-1:0] grant_1hot,
    output logic                   grant_valid
);

    // All sources above source 0
    localparam logic [NUM_SOURCES-1:0] ABOVE_ZERO = {{(NUM_SOURCES - 1){1'b1}}, 1'b0};

    logic [NUM_SOURCES-1:0] upper_mask;   // Sources after the last grant
    logic [NUM_SOURCES-1:0] lower_mask;   // Last grant and everything below
    logic [NUM_SOURCES-1:0] upper_req;
    logic [NUM_SOURCES-1:0] lower_req;
    logic [SRC_W-1:0]       upper_sel;
    logic [SRC_W-1:0]       lower_sel;

    // Out of reset the last grant counts as source 0
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            upper_mask <= ABOVE_ZERO;
            lower_mask <= ~ABOVE_ZERO;
        end else if (grant_valid && !hold[grant]) begin
            upper_mask <= ABOVE_ZERO << grant;
            lower_mask <= ~(ABOVE_ZERO << grant);
        end
    end

    assign upper_req = request & upper_mask;
    assign lower_req = request & lower_mask;

    always_comb begin
        upper_sel = '0;
        lower_sel = '0;
        // Walk down so the lowest set bit is left standing
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (upper_req[i])
                upper_sel = SRC_W'(i);
            if (lower_req[i])
                lower_sel = SRC_W'(i);
        end
    end

    always_comb begin
        grant_valid       = |request;
        grant             = (|upper_req) ? upper_sel : lower_sel;   // Higher part first
        grant_1hot        = '0;
        grant_1hot[grant] = 1'b1;   // Not gated, user checks grant_valid
    end

endmodule

/* design/drain_control.sv */
`timescale 1ns/1ps

module drain_control #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [NUM_SOURCES-1:0] not_empty,
    input  logic [NUM_SOURCES-1:0] head_last,
    input  logic [SRC_W-1:0]       grant,
    input  logic [NUM_SOURCES-1:0] grant_1hot,
    input  logic                   grant_valid,
    output logic [NUM_SOURCES-1:0] request,
    output logic [NUM_SOURCES-1:0] hold,
    output logic [NUM_SOURCES-1:0] pop,
    output logic                   pop_valid,
    output logic [SRC_W-1:0]       pop_source
);

    import merger_types_pkg::*;

    drain_state_t     state;
    drain_state_t     state_next;
    logic [SRC_W-1:0] locked_src;
    logic             granted_last;

    assign granted_last = head_last[grant];

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // A single-word packet never takes the lock
                if (grant_valid && !granted_last)
                    state_next = LOCKED;
            end
            LOCKED: begin
                if (grant_valid && granted_last)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= IDLE;
            locked_src <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && grant_valid)
                locked_src <= grant;
        end
    end

    // While locked only the owner may ask, an empty owner leaves a gap
    always_comb begin
        if (state == LOCKED) begin
            request             = '0;
            request[locked_src] = not_empty[locked_src];
        end else begin
            request = not_empty;
        end
    end

    // Priority moves on only when a packet's last word goes out
    assign hold = ~head_last;

    assign pop        = grant_1hot & {NUM_SOURCES{grant_valid}};
    assign pop_valid  = grant_valid;
    assign pop_source = grant;

endmodule

/* design/output_stage.sv */
`timescale 1ns/1ps

module output_stage #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      pop_valid,
    input  logic [SRC_W-1:0]                          pop_source,
    input  merger_types_pkg::data_t [NUM_SOURCES-1:0] head_data,
    input  logic [NUM_SOURCES-1:0]                    head_last,
    output logic                                      out_valid,
    output merger_types_pkg::data_t                   out_data,
    output logic [SRC_W-1:0]                          out_source,
    output logic                                      out_last
);

    import merger_types_pkg::*;

    data_t sel_data;
    logic  sel_last;

    assign sel_data = head_data[pop_source];
    assign sel_last = head_last[pop_source];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= pop_valid;
            out_last  <= pop_valid && sel_last;   // Low between words
        end
    end

    // Payload only loads on a pop
    always_ff @(posedge clk) begin
        if (pop_valid) begin
            out_data   <= sel_data;
            out_source <= pop_source;
        end
    end

endmodule

/* design/packet_merger_top.sv */
`timescale 1ns/1ps

module packet_merger_top #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    parameter int QUEUE_DEPTH = merger_cfg_pkg::QUEUE_DEPTH_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic [NUM_SOURCES-1:0]                    push,
    input  merger_types_pkg::data_t [NUM_SOURCES-1:0] push_data,
    input  logic [NUM_SOURCES-1:0]                    push_last,
    output logic [NUM_SOURCES-1:0]                    full,
    output logic                                      out_valid,
    output merger_types_pkg::data_t                   out_data,
    output logic [SRC_W-1:0]                          out_source,
    output logic                                      out_last
);

    import merger_types_pkg::*;

    data_t [NUM_SOURCES-1:0] head_data;
    logic [NUM_SOURCES-1:0]  head_last;
    logic [NUM_SOURCES-1:0]  not_empty;
    logic [NUM_SOURCES-1:0]  pop;
    logic [NUM_SOURCES-1:0]  request;
    logic [NUM_SOURCES-1:0]  hold;
    logic [NUM_SOURCES-1:0]  grant_1hot;
    logic [SRC_W-1:0]        grant;
    logic                    grant_valid;
    logic                    pop_valid;
    logic [SRC_W-1:0]        pop_source;

    for (genvar s = 0; s < NUM_SOURCES; s++) begin : gen_queue
        source_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
            .clk       (clk),
            .reset_n   (reset_n),
            .push      (push[s]),
            .push_data (push_data[s]),
            .push_last (push_last[s]),
            .pop       (pop[s]),
            .head_data (head_data[s]),
            .head_last (head_last[s]),
            .not_empty (not_empty[s]),
            .full      (full[s])
        );
    end

    fair_arbiter #(.NUM_SOURCES(NUM_SOURCES)) u_arbiter (
        .clk         (clk),
        .reset_n     (reset_n),
        .request     (request),
        .hold        (hold),
        .grant       (grant),
        .grant_1hot  (grant_1hot),
        .grant_valid (grant_valid)
    );

    drain_control #(.NUM_SOURCES(NUM_SOURCES)) u_control (
        .clk         (clk),
        .reset_n     (reset_n),
        .not_empty   (not_empty),
        .head_last   (head_last),
        .grant       (grant),
        .grant_1hot  (grant_1hot),
        .grant_valid (grant_valid),
        .request     (request),
        .hold        (hold),
        .pop         (pop),
        .pop_valid   (pop_valid),
        .pop_source  (pop_source)
    );

    output_stage #(.NUM_SOURCES(NUM_SOURCES)) u_output (
        .clk        (clk),
        .reset_n    (reset_n),
        .pop_valid  (pop_valid),
        .pop_source (pop_source),
        .head_data  (head_data),
        .head_last  (head_last),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_source (out_source),
        .out_last   (out_last)
    );

endmodule

/* verif/merger_checker.sv */
`timescale 1ns/1ps

module merger_checker #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    parameter int QUEUE_DEPTH = merger_cfg_pkg::QUEUE_DEPTH_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input logic                   clk,
    input logic                   reset_n,
    input logic [NUM_SOURCES-1:0] push,
    input logic [NUM_SOURCES-1:0] full,
    input logic                   out_valid,
    input logic [SRC_W-1:0]       out_source,
    input logic                   out_last
);

    logic [SRC_W-1:0] prev_source;
    logic             packet_open;   // Last valid word was not a last word
    int               push_count [NUM_SOURCES];
    int               assert_failures = 0;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            packet_open <= 1'b0;
            prev_source <= '0;
        end else if (out_valid) begin
            packet_open <= !out_last;
            prev_source <= out_source;
        end
    end

    // Saturates at the depth
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SOURCES; s++) begin
            if (!reset_n)
                push_count[s] <= 0;
            else if (push[s] && push_count[s] < QUEUE_DEPTH)
                push_count[s] <= push_count[s] + 1;
        end
    end

    last_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
        out_last |-> out_valid)
        else begin
            $error("out_last high without out_valid");
            assert_failures++;
        end

    no_interleave: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && packet_open |-> out_source == prev_source)
        else begin
            $error("source changed in the middle of a packet");
            assert_failures++;
        end

    for (genvar s = 0; s < NUM_SOURCES; s++) begin : gen_full
        full_after_depth: assert property (@(posedge clk) disable iff (!reset_n)
            full[s] |-> push_count[s] >= QUEUE_DEPTH)
            else begin
                $error("queue %0d full before receiving enough words", s);
                assert_failures++;
            end
    end

endmodule

/* verif/merger_monitor.sv */
`timescale 1ns/1ps

module merger_monitor #(
    parameter int NUM_SOURCES = merger_cfg_pkg::NUM_SOURCES_DEF,
    localparam int SRC_W = $clog2(NUM_SOURCES)
) (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    out_valid,
    input merger_types_pkg::data_t out_data,
    input logic [SRC_W-1:0]        out_source,
    input logic                    out_last,
    input logic [NUM_SOURCES-1:0]  full
);

    import merger_types_pkg::*;

    string                  exp_name [$];
    int                     exp_src [$];
    data_t                  exp_data [$];
    logic                   exp_last [$];
    int                     pending = 0;
    int                     pass_count = 0;
    int                     fail_count = 0;
    int                     error_count = 0;
    int                     test_errors = 0;
    int                     word_in_test = 0;
    logic [NUM_SOURCES-1:0] was_full = '0;   // Queue has been seen full

    task automatic add_expect(string name, int src, data_t data, logic last);
        exp_name.push_back(name);
        exp_src.push_back(src);
        exp_data.push_back(data);
        exp_last.push_back(last);
        pending++;
    endtask

    task automatic report_error(string name, string what, string expected, string actual);
        $display("error: test %s %s expected %s actual %s", name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic check_word();
        string name;
        int    src;
        data_t data;
        logic  last;
        name = exp_name.pop_front();
        src  = exp_src.pop_front();
        data = exp_data.pop_front();
        last = exp_last.pop_front();
        pending--;
        if (out_source !== src[SRC_W-1:0] || out_data !== data || out_last !== last)
            report_error(name, "word",
                $sformatf("src %0d data %h last %0b", src, data, last),
                $sformatf("src %0d data %h last %0b", out_source, out_data, out_last));
        // First word out of a filled queue
        if (name == "full_level" && word_in_test == 0) begin
            if (!was_full[src])
                report_error(name, "full before drain", "1", "0");
            if (full[src] !== 1'b0)
                report_error(name, "full after first pop", "0", $sformatf("%b", full[src]));
            was_full[src] = 1'b0;
        end
        word_in_test++;
        if (exp_name.size() == 0 || exp_name[0] != name) begin
            if (test_errors == 0) begin
                $display("test %s passed, %0d words", name, word_in_test);
                pass_count++;
            end else begin
                $display("test %s failed with %0d errors", name, test_errors);
                fail_count++;
            end
            test_errors  = 0;
            word_in_test = 0;
        end
    endtask

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            if (exp_name.size() == 0) begin
                $display("output word %h from source %0d arrived with nothing left to expect",
                         out_data, out_source);
                error_count++;
            end else begin
                check_word();
            end
        end
        if (reset_n)
            was_full = was_full | full;
    end

endmodule

/* verif/merger_tb.sv */
`timescale 1ns/1ps

module merger_tb;

    import merger_cfg_pkg::*;
    import merger_types_pkg::*;

    localparam int NUM_SOURCES = NUM_SOURCES_DEF;
    localparam int QUEUE_DEPTH = QUEUE_DEPTH_DEF;
    localparam int SRC_W = $clog2(NUM_SOURCES);

    logic                    clk;
    logic                    reset_n;
    logic [NUM_SOURCES-1:0]  push;
    data_t [NUM_SOURCES-1:0] push_data;
    logic [NUM_SOURCES-1:0]  push_last;
    logic [NUM_SOURCES-1:0]  full;
    logic                    out_valid;
    data_t                   out_data;
    logic [SRC_W-1:0]        out_source;
    logic                    out_last;

    int    push_cycle [$];
    int    push_src [$];
    data_t push_word [$];
    logic  push_flag [$];
    int    push_idx;
    int    cycle;
    int    timeout_limit;
    int    expect_total;
    logic  timed_out;
    logic  load_failed;

    packet_merger_top #(.NUM_SOURCES(NUM_SOURCES), .QUEUE_DEPTH(QUEUE_DEPTH)) UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .push       (push),
        .push_data  (push_data),
        .push_last  (push_last),
        .full       (full),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_source (out_source),
        .out_last   (out_last)
    );

    merger_monitor #(.NUM_SOURCES(NUM_SOURCES)) u_monitor (
        .clk        (clk),
        .reset_n    (reset_n),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_source (out_source),
        .out_last   (out_last),
        .full       (full)
    );

    bind packet_merger_top merger_checker #(
        .NUM_SOURCES (NUM_SOURCES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_checker (
        .clk        (clk),
        .reset_n    (reset_n),
        .push       (push),
        .full       (full),
        .out_valid  (out_valid),
        .out_source (out_source),
        .out_last   (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic read_vectors();
        int    fd;
        int    rc;
        int    c;
        int    s;
        int    d;
        int    l;
        string kind;
        string name;
        string rest;
        fd = $fopen("verif/merger_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file verif/merger_vectors.txt");
            load_failed = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", kind);
            if (rc != 1)
                break;
            if (kind == "push") begin
                rc = $fscanf(fd, "%d %d %h %d", c, s, d, l);
                push_cycle.push_back(c);
                push_src.push_back(s);
                push_word.push_back(data_t'(d));
                push_flag.push_back(l[0]);
            end else if (kind == "expect") begin
                rc = $fscanf(fd, "%s %d %h %d", name, s, d, l);
                u_monitor.add_expect(name, s, data_t'(d), l[0]);
                expect_total++;
            end else begin
                rc = $fgets(rest, fd);   // Comment line
            end
        end
        $fclose(fd);
    endtask

    // Applies every push listed for the current cycle
    task automatic drive_pushes();
        push      = '0;
        push_last = '0;
        while (push_idx < push_cycle.size() && push_cycle[push_idx] == cycle) begin
            push[push_src[push_idx]]      = 1'b1;
            push_data[push_src[push_idx]] = push_word[push_idx];
            push_last[push_src[push_idx]] = push_flag[push_idx];
            push_idx++;
        end
    endtask

    initial begin
        reset_n      = 1'b0;
        push         = '0;
        push_data    = '0;
        push_last    = '0;
        push_idx     = 0;
        cycle        = 0;
        expect_total = 0;
        timed_out    = 1'b0;
        load_failed  = 1'b0;
        read_vectors();
        timeout_limit = expect_total + 50;
        if (push_cycle.size() > 0)
            timeout_limit = timeout_limit + push_cycle[$];
        repeat (16) @(posedge clk);
        #2 reset_n = 1'b1;
        while (!timed_out && (push_idx < push_cycle.size() || u_monitor.pending > 0)) begin
            @(posedge clk);
            #2;
            cycle++;
            drive_pushes();
            if (cycle >= timeout_limit)
                timed_out = 1'b1;
        end
        repeat (3) @(posedge clk);   // Catch stray words
        if (timed_out)
            $display("run timed out at cycle %0d with %0d expected words still missing",
                     cycle, u_monitor.pending);
        $display("tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 u_monitor.pass_count, u_monitor.fail_count, u_monitor.error_count,
                 UUT.u_checker.assert_failures);
        if (!timed_out && !load_failed && expect_total > 0 && u_monitor.fail_count == 0
                && u_monitor.error_count == 0 && UUT.u_checker.assert_failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/merger_vectors.txt */
# push   cycle source data(hex) last
# expect test  source data(hex) last
push 1 0 1000 0
push 1 1 1100 0
push 1 2 1200 0
push 1 3 1300 0
push 2 0 1001 1
push 2 1 1101 1
push 2 2 1201 1
push 2 3 1301 1
push 14 3 2300 1
push 17 1 2100 1
push 17 3 2301 1
push 22 2 3200 0
push 23 2 3201 0
push 24 2 3202 1
push 30 0 4000 0
push 31 0 4001 0
push 32 1 4100 1
push 36 0 4002 1
push 42 0 5000 0
push 43 3 5300 0
push 44 3 5301 0
push 45 3 5302 0
push 46 3 5303 0
push 47 3 5304 0
push 48 3 5305 0
push 49 3 5306 0
push 50 3 5307 1
push 53 0 5001 1
expect round_robin 1 1100 0
expect round_robin 1 1101 1
expect round_robin 2 1200 0
expect round_robin 2 1201 1
expect round_robin 3 1300 0
expect round_robin 3 1301 1
expect round_robin 0 1000 0
expect round_robin 0 1001 1
expect wrap_order 3 2300 1
expect wrap_order 1 2100 1
expect wrap_order 3 2301 1
expect single_packet 2 3200 0
expect single_packet 2 3201 0
expect single_packet 2 3202 1
expect mid_gap 0 4000 0
expect mid_gap 0 4001 0
expect mid_gap 0 4002 1
expect mid_gap 1 4100 1
expect full_lock 0 5000 0
expect full_lock 0 5001 1
expect full_level 3 5300 0
expect full_level 3 5301 0
expect full_level 3 5302 0
expect full_level 3 5303 0
expect full_level 3 5304 0
expect full_level 3 5305 0
expect full_level 3 5306 0
expect full_level 3 5307 1

/* verilog.f */
design/merger_cfg_pkg.sv
design/merger_types_pkg.sv
design/source_queue.sv
design/fair_arbiter.sv
design/drain_control.sv
design/output_stage.sv
design/packet_merger_top.sv
verif/merger_checker.sv
verif/merger_monitor.sv
verif/merger_tb.sv
